/* armTrap.f */
+incdir+source
source/trapCausePkg.sv
source/pipeCtrlPkg.sv
source/trapDecode.sv
source/trapSequencer.sv
source/trapVector.sv
source/armTrap.sv
dv/armTrap_sva.sv
dv/armTrapTb.sv

/* Makefile */
# Verilator flow for the armTrap testbench

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module armTrapTb -Mdir obj_dir -f armTrap.f

run: compile
	./obj_dir/VarmTrapTb +verilator+error+limit+100 > run.log 2>&1; cat run.log
	grep -qx "test passed" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean

/* dv/armTrapTb.sv */
module armTrapTb
  import trapCausePkg::*;
  import pipeCtrlPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Directed phases and the random phase come to roughly 300 cycles
  localparam int timeoutCycles = 600;
  localparam int randomCycles  = 250;

  logic       clk;
  logic       reset;
  trapCauseT  causeE;
  logic       dataAbort;
  logic       irq;
  logic       fiq;
  logic       irqEnabled;
  logic       fiqEnabled;
  pipeStatusT pipe;
  trapCauseT  causeM;
  flushT      flush;
  logic       stallD;
  logic       resetMicrop;
  logic       interrupting;
  logic       dataAbortCycle2;
  logic       irqAssert;
  logic       fiqAssert;
  trapVectorT vector;
  logic       savePc;
  pcOffsetT   pcSelect;

  int          cycleCount;
  logic [31:0] lcgState;

  armTrap DUT (
    .clk             (clk),
    .reset           (reset),
    .causeE          (causeE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .irqEnabled      (irqEnabled),
    .fiqEnabled      (fiqEnabled),
    .pipe            (pipe),
    .causeM          (causeM),
    .flush           (flush),
    .stallD          (stallD),
    .resetMicrop     (resetMicrop),
    .interrupting    (interrupting),
    .dataAbortCycle2 (dataAbortCycle2),
    .irqAssert       (irqAssert),
    .fiqAssert       (fiqAssert),
    .vector          (vector),
    .savePc          (savePc),
    .pcSelect        (pcSelect)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Idle pipe, enables left alone
  task automatic clearInputs();
    causeE    = '0;
    dataAbort = 1'b0;
    irq       = 1'b0;
    fiq       = 1'b0;
    pipe      = '0;
  endtask

  task automatic nextCycle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Outputs are settled by the falling edge
  task automatic waitTaken();
    while (!(irqAssert || fiqAssert)) begin
      @(negedge clk);
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout, the run did not finish within %0d cycles", timeoutCycles);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  // First assertion failure ends the run
  always @(negedge clk) begin
    if (DUT.uSva.failSeen) begin
      $display("test failed");
      $fatal(1, "assertion failure in armTrapSva");
    end
  end

  initial begin
    logic [31:0] r2;
    reset      = 1'b1;
    irqEnabled = 1'b0;
    fiqEnabled = 1'b0;
    lcgState   = 32'd76386;
    clearInputs();
    nextCycle(2);
    reset = 1'b0;
    nextCycle(2);

    // Data abort, two cycle sequence
    dataAbort = 1'b1;
    nextCycle(1);
    dataAbort = 1'b0;
    nextCycle(3);

    // Each synchronous cause alone, then all three for priority
    for (int i = 0; i < 4; i++) begin
      causeE = (i == 3) ? trapCauseT'(3'b111) : trapCauseT'(3'b001 << i);
      nextCycle(1);
      causeE = '0;
      nextCycle(1);
    end

    // Plain IRQ with no stalls
    irqEnabled = 1'b1;
    nextCycle(1);
    irq = 1'b1;
    waitTaken();
    nextCycle(1);
    irq = 1'b0;
    nextCycle(2);

    // Both requests, FIQ should win
    fiqEnabled = 1'b1;
    nextCycle(1);
    irq = 1'b1;
    fiq = 1'b1;
    waitTaken();
    nextCycle(1);
    clearInputs();
    nextCycle(2);

    // D stall delays entry, then PC write and E stalls hold each phase
    pipe.stallD = 1'b1;
    irq         = 1'b1;
    nextCycle(3);
    pipe.stallD = 1'b0;
    nextCycle(1);
    pipe.pcWrPendingF = 1'b1;
    nextCycle(2);
    pipe.pcWrPendingF = 1'b0;
    nextCycle(1);
    pipe.stallE = 1'b1;
    nextCycle(2);
    pipe.stallE = 1'b0;
    waitTaken();
    pipe.stallE = 1'b1;
    nextCycle(2);
    pipe.stallE = 1'b0;
    nextCycle(1);
    irq = 1'b0;
    nextCycle(2);

    // Request dropped while in intM
    irq = 1'b1;
    nextCycle(2);
    irq = 1'b0;
    nextCycle(3);

    // Enable rises late, then falls during the walk
    irqEnabled = 1'b0;
    irq        = 1'b1;
    nextCycle(3);
    irqEnabled = 1'b1;
    nextCycle(2);
    irqEnabled = 1'b0;
    nextCycle(3);
    irq        = 1'b0;
    irqEnabled = 1'b1;
    nextCycle(2);

    // Random mix, upper LCG bits only
    repeat (randomCycles) begin
      lcgState          = lcgNext(lcgState);
      r2                = lcgNext(lcgState ^ 32'h5a5a_0000);
      dataAbort         = (lcgState[31:28] == 4'd0);
      causeE            = (lcgState[27:25] == 3'd0) ? trapCauseT'(lcgState[24:22]) : '0;
      irq               = lcgState[21] | lcgState[20];
      fiq               = lcgState[19] & lcgState[18];
      irqEnabled        = lcgState[17] | lcgState[16];
      fiqEnabled        = lcgState[15] | lcgState[14];
      pipe.stallD       = lcgState[13] & lcgState[12];
      pipe.stallE       = r2[31] & r2[30];
      pipe.pcWrPendingF = r2[29] & r2[28] & r2[27];
      pipe.pcUpdateW    = r2[26];
      nextCycle(1);
    end

    clearInputs();
    nextCycle(3);
    if (DUT.uSva.failSeen) begin
      $display("test failed");
      $fatal(1, "assertion failure in armTrapSva");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* dv/armTrap_sva.sv */
module armTrapSva
  import trapCausePkg::*;
  import pipeCtrlPkg::*;
(
  input logic       clk,
  input logic       reset,
  input trapCauseT  causeE,
  input logic       dataAbort,
  input logic       irq,
  input logic       fiq,
  input logic       irqEnabled,
  input logic       fiqEnabled,
  input pipeStatusT pipe,
  input trapCauseT  causeM,
  input flushT      flush,
  input logic       stallD,
  input logic       resetMicrop,
  input logic       interrupting,
  input logic       dataAbortCycle2,
  input logic       irqAssert,
  input logic       fiqAssert,
  input trapVectorT vector,
  input logic       savePc,
  input pcOffsetT   pcSelect
);

  timeunit 1ns;
  timeprecision 1ps;

  // Raised by any failing assertion, watched from the testbench
  bit failSeen;

  // Enables as the sequencer should see them, one cycle late
  logic irqEnQ;
  logic fiqEnQ;
  logic fiqPend;
  logic pend;

  // PC write retiring in W, captured while E moves
  logic unstallQ;

  // Event classes seen while the sequencer is in ready
  logic anyCause;
  logic taken;
  logic abortReady;
  logic syncReady;
  logic quietReady;
  logic intEntry;

  // Previous cycle copies for expected values
  logic      entryQ;
  flushT     flushQ;
  trapCauseT causeQ;

  // Highest priority synchronous cause wins the vector
  function automatic trapVectorT syncVector(input trapCauseT c);
    if (c.prefetchAbort) begin
      return vecPrefetchAbort;
    end
    if (c.undefinedInstr) begin
      return vecUndef;
    end
    if (c.swi) begin
      return vecSwi;
    end
    return vecReset;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      irqEnQ   <= 1'b0;
      fiqEnQ   <= 1'b0;
      unstallQ <= 1'b0;
      entryQ   <= 1'b0;
      flushQ   <= '0;
      causeQ   <= '0;
    end else begin
      irqEnQ <= irqEnabled;
      fiqEnQ <= fiqEnabled;
      entryQ <= intEntry;
      flushQ <= flush;
      causeQ <= causeE;
      if (!pipe.stallE) begin
        unstallQ <= pipe.pcUpdateW;
      end
    end
  end

  assign fiqPend    = fiq & fiqEnQ;
  assign pend       = fiqPend | (irq & irqEnQ);
  assign anyCause   = |causeE;
  assign taken      = irqAssert | fiqAssert;
  assign abortReady = !reset && !interrupting && dataAbort;
  assign syncReady  = !reset && !interrupting && !dataAbort && anyCause;
  assign quietReady = !reset && !interrupting && !dataAbort && !anyCause;
  // Interrupt walk starts only when D is free
  assign intEntry   = quietReady && pend && !pipe.stallD;

  // Reset vector is forced for the whole reset
  aResetVec: assert property (@(posedge clk) reset |-> savePc && vector == vecReset)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t vector expected %0d got %0d, savePc expected 1 got %b",
             $time, vecReset, vector, savePc);
    end

  aResetClean: assert property (@(posedge clk)
    $fell(reset) |-> flush == '0 && !stallD && !interrupting && !taken)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t flush expected 0000 got %b, stallD %b interrupting %b taken %b",
             $time, flush, stallD, interrupting, taken);
    end

  // First abort cycle kills every stage
  aAbortFirst: assert property (@(posedge clk) disable iff (reset)
    abortReady |-> flush == 4'b1111 && stallD && resetMicrop)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t flush expected 1111 got %b, stallD expected 1 got %b, resetMicrop %b",
             $time, flush, stallD, resetMicrop);
    end

  aAbortSecond: assert property (@(posedge clk) disable iff (reset)
    $past(abortReady) |-> dataAbortCycle2 && flush == 4'b1011 &&
                          vector == vecDataAbort && pcSelect == pcPlus0)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t flush expected 1011 got %b, vector expected %0d got %0d, pcSelect %0d",
             $time, flush, vecDataAbort, vector, pcSelect);
    end

  // Abort is over after exactly two cycles
  aAbortEnd: assert property (@(posedge clk) disable iff (reset)
    $past(abortReady, 2) |-> !interrupting)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t interrupting expected 0 got %b", $time, interrupting);
    end

  aCauseM: assert property (@(posedge clk) disable iff (reset) causeM == causeQ)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t causeM expected %b got %b", $time, causeQ, causeM);
    end

  aSync: assert property (@(posedge clk) disable iff (reset)
    syncReady |-> flush == 4'b1010 && savePc && pcSelect == pcPlus0 &&
                  vector == syncVector(causeE))
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t vector expected %0d got %0d, flush %b savePc %b pcSelect %0d",
             $time, syncVector(causeE), vector, flush, savePc, pcSelect);
    end

  // Nothing to vector, so no save, normal offset and no strobes
  aQuiet: assert property (@(posedge clk) disable iff (reset)
    quietReady |-> flush == '0 && !savePc && pcSelect == pcPlus8 &&
                   !taken && !resetMicrop)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t flush expected 0000 got %b, savePc expected 0 got %b, pcSelect %0d",
             $time, flush, savePc, pcSelect);
    end

  // From ready only an unstalled pending interrupt leaves the state
  aReadyNext: assert property (@(posedge clk) disable iff (reset)
    !interrupting && !dataAbort |=> interrupting == entryQ)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t interrupting expected %b got %b", $time, entryQ, interrupting);
    end

  aIntE: assert property (@(posedge clk) disable iff (reset)
    entryQ |-> flush == 4'b0100 && stallD)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t flush expected 0100 got %b, stallD expected 1 got %b",
             $time, flush, stallD);
    end

  // A PC write in flight keeps the walk in intE
  aPcWrHold: assert property (@(posedge clk) disable iff (reset)
    entryQ && pend && pipe.pcWrPendingF |=> flush == 4'b0100 && stallD && !taken)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t flush expected 0100 got %b, stallD %b taken %b",
             $time, flush, stallD, taken);
    end

  // First intM cycle releases D only after a PC write retired in W
  aIntM: assert property (@(posedge clk) disable iff (reset)
    entryQ && pend && !pipe.stallE && !pipe.pcWrPendingF |=>
      flush == 4'b0100 && stallD == !unstallQ && !taken)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t stallD expected %b got %b, flush expected 0100 got %b, taken %b",
             $time, !unstallQ, stallD, flush, taken);
    end

  aStallHold: assert property (@(posedge clk) disable iff (reset)
    interrupting && !dataAbortCycle2 && pend && pipe.stallE |=>
      interrupting && flush == flushQ)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t flush expected %b got %b, interrupting %b",
             $time, flushQ, flush, interrupting);
    end

  // Request gone, back to ready with no strobe
  aDrop: assert property (@(posedge clk) disable iff (reset)
    interrupting && !dataAbortCycle2 && !pend |=> !interrupting && !taken)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t interrupting expected 0 got %b, taken expected 0 got %b",
             $time, interrupting, taken);
    end

  aTakeTime: assert property (@(posedge clk) disable iff (reset)
    $past(intEntry, 3) && $past(pend && !pipe.stallE && !pipe.pcWrPendingF, 2) &&
    $past(pend && !pipe.stallE) |-> taken)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t taken expected 1 got %b", $time, taken);
    end

  aTakeKind: assert property (@(posedge clk) disable iff (reset)
    taken |-> fiqAssert == fiqPend && irqAssert == !fiqPend &&
              vector == (fiqPend ? vecFiq : vecIrq))
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t fiqAssert expected %b got %b, vector got %0d",
             $time, fiqPend, fiqAssert, vector);
    end

  aTakePc: assert property (@(posedge clk) disable iff (reset)
    taken |-> pcSelect == pcPlus4 && flush == 4'b1000)
    else begin
      failSeen = 1'b1;
      $error("ERROR %0t pcSelect expected %0d got %0d, flush expected 1000 got %b",
             $time, pcPlus4, pcSelect, flush);
    end

endmodule

bind armTrap armTrapSva uSva (
  .clk             (clk),
  .reset           (reset),
  .causeE          (causeE),
  .dataAbort       (dataAbort),
  .irq             (irq),
  .fiq             (fiq),
  .irqEnabled      (irqEnabled),
  .fiqEnabled      (fiqEnabled),
  .pipe            (pipe),
  .causeM          (causeM),
  .flush           (flush),
  .stallD          (stallD),
  .resetMicrop     (resetMicrop),
  .interrupting    (interrupting),
  .dataAbortCycle2 (dataAbortCycle2),
  .irqAssert       (irqAssert),
  .fiqAssert       (fiqAssert),
  .vector          (vector),
  .savePc          (savePc),
  .pcSelect        (pcSelect)
);

/* source/armTrap.sv */
module armTrap
  import trapCausePkg::*;
  import pipeCtrlPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  trapCauseT  causeE,
  input  logic       dataAbort,
  input  logic       irq,
  input  logic       fiq,
  input  logic       irqEnabled,
  input  logic       fiqEnabled,
  input  pipeStatusT pipe,
  output trapCauseT  causeM,
  output flushT      flush,
  output logic       stallD,
  output logic       resetMicrop,
  output logic       interrupting,
  output logic       dataAbortCycle2,
  output logic       irqAssert,
  output logic       fiqAssert,
  output trapVectorT vector,
  output logic       savePc,
  output pcOffsetT   pcSelect
);

  // Between decode and sequencer
  logic interruptPending;
  logic unstallD;

  // Into the vector block
  logic fiqPending;
  logic intTake;

  // Enable sync, cause delay and pending interrupt
  trapDecode uDecode (
    .clk              (clk),
    .reset            (reset),
    .causeE           (causeE),
    .irq              (irq),
    .fiq              (fiq),
    .irqEnabled       (irqEnabled),
    .fiqEnabled       (fiqEnabled),
    .pipe             (pipe),
    .causeM           (causeM),
    .interruptPending (interruptPending),
    .fiqPending       (fiqPending),
    .unstallD         (unstallD)
  );

  // Flush and stall FSM
  trapSequencer uSequencer (
    .clk              (clk),
    .reset            (reset),
    .dataAbort        (dataAbort),
    .causeE           (causeE),
    .interruptPending (interruptPending),
    .unstallD         (unstallD),
    .pipe             (pipe),
    .flush            (flush),
    .stallD           (stallD),
    .resetMicrop      (resetMicrop),
    .interrupting     (interrupting),
    .dataAbortCycle2  (dataAbortCycle2),
    .intTake          (intTake)
  );

  // Vector priority and PC save select
  trapVector uVector (
    .reset           (reset),
    .causeE          (causeE),
    .dataAbortCycle2 (dataAbortCycle2),
    .intTake         (intTake),
    .fiqPending      (fiqPending),
    .vector          (vector),
    .savePc          (savePc),
    .pcSelect        (pcSelect),
    .irqAssert       (irqAssert),
    .fiqAssert       (fiqAssert)
  );

endmodule

/* source/trapVector.sv */
`include "armTrap_config.svh"

module trapVector
  import trapCausePkg::*;
(
  input  logic       reset,
  input  trapCauseT  causeE,
  input  logic       dataAbortCycle2,
  input  logic       intTake,
  input  logic       fiqPending,
  output trapVectorT vector,
  output logic       savePc,
  output pcOffsetT   pcSelect,
  output logic       irqAssert,
  output logic       fiqAssert
);

  // Active events, MSB has the highest priority
  logic [`TRAP_CAUSE_COUNT-1:0] events;

  // Any synchronous cause present in E
  logic syncCause;

  // FIQ beats IRQ when both are pending at the take
  assign fiqAssert = intTake & fiqPending;
  assign irqAssert = intTake & ~fiqPending;

  assign events = {reset, fiqAssert, irqAssert, dataAbortCycle2,
                   causeE.prefetchAbort, causeE.undefinedInstr, causeE.swi};

  assign syncCause = |causeE;

  // Every vectored event also saves the PC
  assign savePc = |events;

  // Fixed priority vector select
  always_comb begin
    if (events[6]) begin
      vector = vecReset;
    end else if (events[5]) begin
      vector = vecFiq;
    end else if (events[4]) begin
      vector = vecIrq;
    end else if (events[3]) begin
      vector = vecDataAbort;
    end else if (events[2]) begin
      vector = vecPrefetchAbort;
    end else if (events[1]) begin
      vector = vecUndef;
    end else if (events[0]) begin
      vector = vecSwi;
    end else begin
      vector = vecReset;
    end
  end

  // Which PC offset goes to the link register
  always_comb begin
    if (irqAssert || fiqAssert) begin
      pcSelect = pcPlus4;
    end else if (syncCause || dataAbortCycle2) begin
      pcSelect = pcPlus0;
    end else begin
      pcSelect = pcPlus8;
    end
  end

endmodule

/* source/trapSequencer.sv */
module trapSequencer
  import trapCausePkg::*;
  import pipeCtrlPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       dataAbort,
  input  trapCauseT  causeE,
  input  logic       interruptPending,
  input  logic       unstallD,
  input  pipeStatusT pipe,
  output flushT      flush,
  output logic       stallD,
  output logic       resetMicrop,
  output logic       interrupting,
  output logic       dataAbortCycle2,
  output logic       intTake
);

  seqStateT state;
  seqStateT nextState;

  // Any synchronous cause present in E
  logic syncCause;

  assign syncCause = |causeE;

  // State register
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  // Mealy next state, flush pattern and D stall
  always_comb begin
    nextState = ready;
    flush     = '0;
    stallD    = 1'b0;
    case (state)
      ready: begin
        if (dataAbort) begin
          // Abort seen in M, kill everything behind it
          // D is stalled so its flush does not matter yet
          flush     = 4'b1111;
          stallD    = 1'b1;
          nextState = dataAbort2;
        end else if (syncCause) begin
          // Single cycle trap from E
          // Drop the instruction in D and the bubble going to M
          flush     = 4'b1010;
          nextState = ready;
        end else if (interruptPending) begin
          // Wait until D is free to move before starting the walk
          nextState = pipe.stallD ? ready : intE;
        end else begin
          nextState = ready;
        end
      end
      dataAbort2: begin
        // PC gets saved this cycle, clear D and the tail again
        flush     = 4'b1011;
        nextState = ready;
      end
      intE: begin
        // Last good instruction sits in E
        // PC writes stall the whole front, so hold while one is pending
        flush  = 4'b0100;
        stallD = 1'b1;
        if (!interruptPending) begin
          nextState = ready;
        end else if (pipe.stallE || pipe.pcWrPendingF) begin
          nextState = intE;
        end else begin
          nextState = intM;
        end
      end
      intM: begin
        // Last good instruction in M
        // Release D if a branch target must get in
        flush  = 4'b0100;
        stallD = !unstallD;
        if (!interruptPending) begin
          nextState = ready;
        end else if (pipe.stallE) begin
          nextState = intM;
        end else begin
          nextState = intW;
        end
      end
      intW: begin
        // Last good instruction retires, interrupt is taken here
        flush = 4'b1000;
        if (!interruptPending) begin
          nextState = ready;
        end else if (pipe.stallE) begin
          nextState = intW;
        end else begin
          nextState = ready;
        end
      end
      default: begin
        nextState = ready;
      end
    endcase
  end

  // Micro-op sequence is abandoned on a data abort
  assign resetMicrop = dataAbort;

  // Phase flags for the vector block and the datapath
  assign interrupting    = (state != ready);
  assign dataAbortCycle2 = (state == dataAbort2);
  assign intTake         = (state == intW);

endmodule

/* source/trapDecode.sv */
module trapDecode
  import trapCausePkg::*;
  import pipeCtrlPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  trapCauseT  causeE,
  input  logic       irq,
  input  logic       fiq,
  input  logic       irqEnabled,
  input  logic       fiqEnabled,
  input  pipeStatusT pipe,
  output trapCauseT  causeM,
  output logic       interruptPending,
  output logic       fiqPending,
  output logic       unstallD
);

  // Enables after the rising edge sync
  logic irqEnSync;
  logic fiqEnSync;

  // Status register writes land on the falling edge
  // Resample the enables here so the sequencer sees a clean level
  always_ff @(posedge clk) begin
    if (reset) begin
      irqEnSync <= 1'b0;
      fiqEnSync <= 1'b0;
    end else begin
      irqEnSync <= irqEnabled;
      fiqEnSync <= fiqEnabled;
    end
  end

  // Carry the E causes one stage further
  // Status register save happens with the trap in M,
  // after the last good instruction had its chance to set flags
  always_ff @(posedge clk) begin
    if (reset) begin
      causeM <= '0;
    end else begin
      causeM <= causeE;
    end
  end

  // Remember a PC write retiring in W while E is moving
  // Lets a branch target slip into D during the intM phase
  always_ff @(posedge clk) begin
    if (reset) begin
      unstallD <= 1'b0;
    end else if (!pipe.stallE) begin
      unstallD <= pipe.pcUpdateW;
    end
  end

  // FIQ request gated by its synced enable
  assign fiqPending = fiq & fiqEnSync;

  // Any enabled request starts or keeps the interrupt walk
  assign interruptPending = fiqPending | (irq & irqEnSync);

endmodule

/* source/pipeCtrlPkg.sv */
package pipeCtrlPkg;

  // Trap sequencer states
  // ready is the normal running state
  // dataAbort2 is the second cycle of a data abort
  // intE, intM, intW follow the last good instruction down the pipe
  typedef enum logic [2:0] {
    ready      = 3'd0,
    dataAbort2 = 3'd1,
    intE       = 3'd2,
    intM       = 3'd3,
    intW       = 3'd4
  } seqStateT;

  // Per stage flush requests, D is the MSB
  typedef struct packed {
    logic d;
    logic e;
    logic m;
    logic w;
  } flushT;

  // Status coming back from the hazard unit
  // stallD holds off entry into an interrupt
  // pcWrPendingF means a PC write is still in flight
  // pcUpdateW marks a PC write retiring in W
  typedef struct packed {
    logic stallD;
    logic stallE;
    logic pcWrPendingF;
    logic pcUpdateW;
  } pipeStatusT;

endpackage

/* source/trapCausePkg.sv */
`include "armTrap_config.svh"

package trapCausePkg;

  // Synchronous causes raised by the instruction in E
  // All three trap in a single cycle
  typedef struct packed {
    logic undefinedInstr;
    logic swi;
    logic prefetchAbort;
  } trapCauseT;

  // ARM vector table slots
  // Slot 5 is the unused address exception slot
  typedef enum logic [`TRAP_VEC_WIDTH-1:0] {
    vecReset         = 3'd0,
    vecUndef         = 3'd1,
    vecSwi           = 3'd2,
    vecPrefetchAbort = 3'd3,
    vecDataAbort     = 3'd4,
    vecIrq           = 3'd6,
    vecFiq           = 3'd7
  } trapVectorT;

  // Offset applied to the PC in D when it is saved into the link register
  // Normal flow wants PC+8
  // Synchronous traps and data abort want the faulting address
  // Interrupts return to the instruction after the last one completed
  typedef enum logic [`TRAP_PCSEL_WIDTH-1:0] {
    pcPlus8 = 2'd0,
    pcPlus0 = 2'd1,
    pcPlus4 = 2'd2
  } pcOffsetT;

endpackage

/* source/armTrap_config.svh */
`ifndef ARMTRAP_CONFIG_SVH
`define ARMTRAP_CONFIG_SVH

// Widths fixed by the architecture

// Exception vector slot index
// Eight slots, slot 5 unused
`define TRAP_VEC_WIDTH 3

// Saved PC offset select
// Covers PC+8, PC+0 and PC+4
`define TRAP_PCSEL_WIDTH 2

// Event sources feeding the vector priority
// Reset, fiq, irq, data abort, prefetch abort, undefined, swi
`define TRAP_CAUSE_COUNT 7

`endif
